// File: alu/exec_alu.sv
// Result-1 ALU: sized integer ops, shifts and packed MMX adds with flag generation
`include "exec_config.svh"

module exec_alu (
    input  exec_pkg::uop_t     uop,
    input  exec_pkg::eflags_t  flags_in,
    output exec_pkg::op_word_u result,
    output exec_pkg::eflags_t  flags_out
);

    logic [`EXEC_DW_W-1:0]   a;            // Low dword of op1
    logic [`EXEC_DW_W-1:0]   b;            // Low dword of op2
    logic [`EXEC_DW_W-1:0]   size_mask;
    logic [4:0]              msb;          // Sign bit index at op size
    logic [`EXEC_DW_W-1:0]   a_m;
    logic [`EXEC_DW_W-1:0]   b_m;
    logic [`EXEC_DW_W-1:0]   a_sx;         // op1 sign extended from op size
    logic [`EXEC_DW_W:0]     sum;
    logic [`EXEC_CNT_W-1:0]  cnt;
    logic [2*`EXEC_DW_W-1:0] sal_wide;
    logic [`EXEC_DW_W:0]     sar_wide;     // Extra low bit catches last bit out
    logic [`EXEC_DW_W-1:0]   r;
    logic                    sized_op;     // Merge r into low dword of op1
    logic                    szp_upd;

    assign a = uop.op1.dw[0];
    assign b = uop.op2.dw[0];

    always_comb begin
        case (uop.size)
            exec_pkg::SZ_1: begin
                size_mask = 32'h0000_00ff;
                msb       = 5'd7;
                a_sx      = {{24{a[7]}}, a[7:0]};
            end
            exec_pkg::SZ_2: begin
                size_mask = 32'h0000_ffff;
                msb       = 5'd15;
                a_sx      = {{16{a[15]}}, a[15:0]};
            end
            default: begin
                size_mask = 32'hffff_ffff;
                msb       = 5'd31;
                a_sx      = a;
            end
        endcase
    end

    assign a_m      = a & size_mask;
    assign b_m      = b & size_mask;
    assign sum      = {1'b0, a_m} + {1'b0, b_m};
    assign cnt      = b[`EXEC_CNT_W-1:0];
    assign sal_wide = {{`EXEC_DW_W{1'b0}}, a_m} << cnt;
    assign sar_wide = $signed({a_sx, 1'b0}) >>> cnt;

    always_comb begin
        r         = '0;
        result    = uop.op2;   // MOV, CMOVC and the pointer ops carry op2
        flags_out = flags_in;
        sized_op  = 1'b0;
        szp_upd   = 1'b0;
        case (uop.op)
            exec_pkg::OP_ADD: begin
                r            = sum[`EXEC_DW_W-1:0];
                sized_op     = 1'b1;
                szp_upd      = 1'b1;
                flags_out.cf = sum[msb+1];
                flags_out.of = (a_m[msb] == b_m[msb]) && (r[msb] != a_m[msb]);
                flags_out.af = a[4] ^ b[4] ^ r[4];
            end
            exec_pkg::OP_AND, exec_pkg::OP_OR: begin
                r            = (uop.op == exec_pkg::OP_AND) ? (a & b) : (a | b);
                sized_op     = 1'b1;
                szp_upd      = 1'b1;
                flags_out.cf = 1'b0;
                flags_out.of = 1'b0;
                flags_out.af = 1'b0;
            end
            exec_pkg::OP_NOT: begin
                r        = ~a;
                sized_op = 1'b1;
            end
            exec_pkg::OP_SAL: begin
                r        = sal_wide[`EXEC_DW_W-1:0];
                sized_op = 1'b1;
                // Zero count leaves the flags alone
                if (cnt != '0) begin
                    szp_upd      = 1'b1;
                    flags_out.cf = sal_wide[msb+1];
                    flags_out.of = r[msb] ^ sal_wide[msb+1];
                    flags_out.af = 1'b0;
                end
            end
            exec_pkg::OP_SAR: begin
                r        = sar_wide[`EXEC_DW_W:1];
                sized_op = 1'b1;
                if (cnt != '0) begin
                    szp_upd      = 1'b1;
                    flags_out.cf = sar_wide[0];
                    flags_out.of = 1'b0;
                    flags_out.af = 1'b0;
                end
            end
            exec_pkg::OP_PADDW: begin
                for (int i = 0; i < `EXEC_DATA_W/`EXEC_W_W; i++) begin
                    result.w[i] = uop.op1.w[i] + uop.op2.w[i];   // Wraps per lane
                end
            end
            exec_pkg::OP_PADDD: begin
                for (int i = 0; i < `EXEC_DATA_W/`EXEC_DW_W; i++) begin
                    result.dw[i] = uop.op1.dw[i] + uop.op2.dw[i];
                end
            end
            exec_pkg::OP_JMP_NEAR, exec_pkg::OP_JCC, exec_pkg::OP_CALL_NEAR: begin
                result.quad = {{(`EXEC_DATA_W-`EXEC_ADDR_W){1'b0}}, uop.eip + a};
            end
            exec_pkg::OP_CLD: flags_out.df = 1'b0;
            exec_pkg::OP_STD: flags_out.df = 1'b1;
            default: ;
        endcase

        if (sized_op) begin
            r           = r & size_mask;
            result.quad = {uop.op1.dw[1], (a & ~size_mask) | r};   // Keep untouched bytes
        end
        if (szp_upd) begin
            flags_out.zf = (r == '0);
            flags_out.sf = r[msb];
            flags_out.pf = ~^r[7:0];   // Even parity of low byte
        end
    end

endmodule

// File: common/exec_config.svh
// Execute stage configuration: datapath widths and pointer step sizes
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Architectural widths
`define EXEC_DATA_W 64      // One operand word, wide enough for MMX
`define EXEC_ADDR_W 32      // EIP and the pointer registers
`define EXEC_OP_W   5       // Op code field

// Packed lane widths inside an operand word
`define EXEC_DW_W   32
`define EXEC_W_W    16

// Shift count field, x86 masks the count to five bits
`define EXEC_CNT_W  5

// Pointer steps per operand size
`define EXEC_STEP_B 32'd1
`define EXEC_STEP_W 32'd2
`define EXEC_STEP_D 32'd4

`endif

// File: common/exec_pkg.sv
// Execute stage types: op codes, operand word views, micro-op and result bundles
`include "exec_config.svh"

package exec_pkg;

    typedef enum logic [`EXEC_OP_W-1:0] {
        OP_ADD,
        OP_AND,
        OP_OR,
        OP_NOT,
        OP_SAL,
        OP_SAR,
        OP_PADDW,
        OP_PADDD,
        OP_MOV,
        OP_CMOVC,
        OP_XCHG,
        OP_MOVS,
        OP_PUSH,
        OP_POP,
        OP_CALL_NEAR,
        OP_RET,
        OP_JMP_NEAR,
        OP_JCC,
        OP_CLD,
        OP_STD
    } exec_op_e;

    // Operand size in bytes, 8 byte encoding unused here
    typedef enum logic [1:0] {
        SZ_1 = 2'd0,
        SZ_2 = 2'd1,
        SZ_4 = 2'd2
    } op_size_e;

    // Same 64 bits seen as a quadword or as packed MMX lanes
    typedef union packed {
        logic [`EXEC_DATA_W-1:0]                          quad;
        logic [`EXEC_DATA_W/`EXEC_DW_W-1:0][`EXEC_DW_W-1:0] dw;
        logic [`EXEC_DATA_W/`EXEC_W_W-1:0][`EXEC_W_W-1:0]   w;
    } op_word_u;

    // cf lands in bit 0
    typedef struct packed {
        logic of;
        logic df;
        logic sf;
        logic zf;
        logic af;
        logic pf;
        logic cf;
    } eflags_t;

    typedef enum logic [1:0] {
        COND_ALWAYS = 2'd0,
        COND_Z      = 2'd1,
        COND_NZ     = 2'd2,
        COND_C      = 2'd3
    } cond_e;

    typedef struct packed {
        exec_op_e                op;
        op_size_e                size;
        op_word_u                op1;
        op_word_u                op2;
        op_word_u                op3;
        op_word_u                op4;
        eflags_t                 fmask;       // Flags this op may write
        cond_e                   cond;
        logic                    is_imm;      // RET imm16 form
        logic [`EXEC_ADDR_W-1:0] eip;
        logic [`EXEC_ADDR_W-1:0] next_eip;
        logic [`EXEC_ADDR_W-1:0] pred_target;
        logic                    pred_taken;
        logic [3:0]              wr_en;       // Bit 0 is res1
    } uop_t;

    typedef struct packed {
        logic [`EXEC_DATA_W-1:0] res1;
        logic [`EXEC_DATA_W-1:0] res2;
        logic [`EXEC_DATA_W-1:0] res3;
        logic [`EXEC_DATA_W-1:0] res4;
        logic [3:0]              wb;
        op_size_e                size;
    } exec_res_t;

    typedef struct packed {
        logic                    valid;
        logic                    taken;
        logic                    correct;
        logic [`EXEC_ADDR_W-1:0] fip;     // Fetch restart address
    } br_res_t;

endpackage

// File: exec_top.f
+incdir+common
common/exec_pkg.sv
alu/exec_alu.sv
hdl/eflags_reg.sv
hdl/cond_eval.sv
hdl/ptr_update.sv
hdl/exec_top.sv
test/exec_tb.sv

// File: hdl/cond_eval.sv
// Condition evaluation: CMOVC skip and branch resolution against the prediction
`include "exec_config.svh"

module cond_eval (
    input  exec_pkg::uop_t          uop,
    input  exec_pkg::eflags_t       flags,
    input  logic [`EXEC_ADDR_W-1:0] target,
    output logic                    skip,
    output exec_pkg::br_res_t       br
);

    logic cond_ok;
    logic is_br;
    logic taken;
    logic target_hit;

    always_comb begin
        case (uop.cond)
            exec_pkg::COND_Z:  cond_ok = flags.zf;
            exec_pkg::COND_NZ: cond_ok = !flags.zf;
            exec_pkg::COND_C:  cond_ok = flags.cf;
            default:           cond_ok = 1'b1;
        endcase
    end

    // CMOVC with carry clear writes nothing
    assign skip = (uop.op == exec_pkg::OP_CMOVC) && !flags.cf;

    assign is_br = (uop.op == exec_pkg::OP_JMP_NEAR) ||
                   (uop.op == exec_pkg::OP_JCC) ||
                   (uop.op == exec_pkg::OP_CALL_NEAR) ||
                   (uop.op == exec_pkg::OP_RET);

    // Only JCC can fall through
    assign taken = is_br && ((uop.op != exec_pkg::OP_JCC) || cond_ok);

    assign target_hit = (target == uop.pred_target);

    always_comb begin
        br.valid   = is_br;
        br.taken   = taken;
        br.fip     = taken ? target : uop.next_eip;
        br.correct = (taken == uop.pred_taken) && (!taken || target_hit);
    end

endmodule

// File: hdl/eflags_reg.sv
// EFLAGS register, each load writes only the bits selected by the op's flag mask

module eflags_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load,
    input  exec_pkg::eflags_t mask,
    input  exec_pkg::eflags_t flags_new,
    output exec_pkg::eflags_t flags
);

    exec_pkg::eflags_t flags_next;

    // Unmasked bits hold, so CLD and STD only touch df
    always_comb begin
        flags_next = (flags & ~mask) | (flags_new & mask);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (load) begin
            flags <= flags_next;
        end
    end

endmodule

// File: hdl/exec_top.sv
// Execute stage top: ALU, flags, condition and pointer logic into one output register
`include "exec_config.svh"

module exec_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_in,
    input  exec_pkg::uop_t      uop,
    output logic                valid_out,
    output exec_pkg::exec_res_t res,
    output exec_pkg::br_res_t   br,
    output exec_pkg::eflags_t   eflags
);

    exec_pkg::op_word_u      alu_res;
    exec_pkg::eflags_t       alu_flags;
    exec_pkg::br_res_t       br_next;
    logic [`EXEC_DATA_W-1:0] res2_next;
    logic [`EXEC_DATA_W-1:0] res3_next;
    logic [`EXEC_DATA_W-1:0] res4_next;
    logic [`EXEC_ADDR_W-1:0] br_target;
    logic                    skip;
    logic                    accept;       // Valid and not a skipped CMOVC

    // Output register stage
    logic [3:0]              wb_q;
    logic                    br_valid_q;
    logic [`EXEC_DATA_W-1:0] res1_q;
    logic [`EXEC_DATA_W-1:0] res2_q;
    logic [`EXEC_DATA_W-1:0] res3_q;
    logic [`EXEC_DATA_W-1:0] res4_q;
    exec_pkg::op_size_e      size_q;
    logic                    br_taken_q;
    logic                    br_correct_q;
    logic [`EXEC_ADDR_W-1:0] br_fip_q;

    exec_alu u_alu (
        .uop       (uop),
        .flags_in  (eflags),
        .result    (alu_res),
        .flags_out (alu_flags)
    );

    eflags_reg u_eflags (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (accept),
        .mask      (uop.fmask),
        .flags_new (alu_flags),
        .flags     (eflags)
    );

    // RET pops its target into op1, the rest compute it in the ALU
    assign br_target = (uop.op == exec_pkg::OP_RET) ? uop.op1.quad[`EXEC_ADDR_W-1:0]
                                                    : alu_res.quad[`EXEC_ADDR_W-1:0];

    cond_eval u_cond (
        .uop    (uop),
        .flags  (eflags),
        .target (br_target),
        .skip   (skip),
        .br     (br_next)
    );

    ptr_update u_ptr (
        .uop  (uop),
        .df   (eflags.df),
        .res2 (res2_next),
        .res3 (res3_next),
        .res4 (res4_next)
    );

    assign accept = valid_in && !skip;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out  <= 1'b0;
            wb_q       <= '0;
            br_valid_q <= 1'b0;
        end else begin
            valid_out  <= accept;
            wb_q       <= uop.wr_en & {4{accept}};
            br_valid_q <= valid_in && br_next.valid;
        end
    end

    always_ff @(posedge clk) begin
        res1_q       <= alu_res.quad;
        res2_q       <= res2_next;
        res3_q       <= res3_next;
        res4_q       <= res4_next;
        size_q       <= uop.size;
        br_taken_q   <= br_next.taken;
        br_correct_q <= br_next.correct;
        br_fip_q     <= br_next.fip;
    end

    assign res = '{res1: res1_q, res2: res2_q, res3: res3_q, res4: res4_q,
                   wb: wb_q, size: size_q};
    assign br  = '{valid: br_valid_q, taken: br_taken_q, correct: br_correct_q,
                   fip: br_fip_q};

endmodule

// File: hdl/ptr_update.sv
// Results 2 to 4: exchange swap, MOVS string pointer steps and stack pointer steps
`include "exec_config.svh"

module ptr_update (
    input  exec_pkg::uop_t          uop,
    input  logic                    df,
    output logic [`EXEC_DATA_W-1:0] res2,
    output logic [`EXEC_DATA_W-1:0] res3,
    output logic [`EXEC_DATA_W-1:0] res4
);

    logic [`EXEC_ADDR_W-1:0] step;        // Size in bytes
    logic [`EXEC_ADDR_W-1:0] str_delta;
    logic [`EXEC_ADDR_W-1:0] stk_delta;
    logic [`EXEC_ADDR_W-1:0] op2_lo;
    logic [`EXEC_ADDR_W-1:0] op3_lo;
    logic [`EXEC_ADDR_W-1:0] op4_lo;
    logic                    is_movs;
    logic                    is_push;
    logic                    is_pop;
    logic                    ret_imm;

    always_comb begin
        case (uop.size)
            exec_pkg::SZ_1: step = `EXEC_STEP_B;
            exec_pkg::SZ_2: step = `EXEC_STEP_W;
            default:        step = `EXEC_STEP_D;
        endcase
    end

    assign op2_lo = uop.op2.quad[`EXEC_ADDR_W-1:0];
    assign op3_lo = uop.op3.quad[`EXEC_ADDR_W-1:0];
    assign op4_lo = uop.op4.quad[`EXEC_ADDR_W-1:0];

    assign is_movs = (uop.op == exec_pkg::OP_MOVS);
    assign is_push = (uop.op == exec_pkg::OP_PUSH) || (uop.op == exec_pkg::OP_CALL_NEAR);
    assign is_pop  = (uop.op == exec_pkg::OP_POP) || (uop.op == exec_pkg::OP_RET);
    assign ret_imm = (uop.op == exec_pkg::OP_RET) && uop.is_imm;

    // ESI and EDI walk down when df is set
    assign str_delta = df ? -step : step;

    always_comb begin
        if (is_push) begin
            stk_delta = -step;
        end else if (ret_imm) begin
            stk_delta = step + op2_lo;   // RET imm16 releases the arguments too
        end else begin
            stk_delta = step;
        end
    end

    // res2: XCHG swap, source pointer for MOVS
    always_comb begin
        if (uop.op == exec_pkg::OP_XCHG) begin
            res2 = uop.op1.quad;
        end else if (is_movs) begin
            res2 = {uop.op2.quad[`EXEC_DATA_W-1:`EXEC_ADDR_W], op2_lo + str_delta};
        end else begin
            res2 = uop.op2.quad;
        end
    end

    // res3: destination pointer for MOVS
    always_comb begin
        if (is_movs) begin
            res3 = {uop.op3.quad[`EXEC_DATA_W-1:`EXEC_ADDR_W], op3_lo + str_delta};
        end else begin
            res3 = uop.op3.quad;
        end
    end

    // res4: ESP
    always_comb begin
        if (is_push || is_pop) begin
            res4 = {uop.op4.quad[`EXEC_DATA_W-1:`EXEC_ADDR_W], op4_lo + stk_delta};
        end else begin
            res4 = uop.op4.quad;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the execute stage testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 --top-module exec_tb \
    --Mdir "$BUILD_DIR" -f exec_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

OUTPUT="$("./$BUILD_DIR/Vexec_tb" 2>&1)"
STATUS=$?
echo "$OUTPUT"
if [ $STATUS -ne 0 ]; then
    echo "Simulation exited with status $STATUS"
    exit 1
fi

if echo "$OUTPUT" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// File: test/exec_tb.sv
// Execute stage testbench that checks directed and random micro-ops against a behavioral model
`include "exec_config.svh"

module exec_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD  = 4;
    localparam int          RST_CYCLES  = 3;
    localparam int          N_DIRECTED  = 16;
    localparam int          N_RANDOM    = 400;
    localparam int          N_CYCLES    = RST_CYCLES + N_DIRECTED + N_RANDOM + N_RANDOM / 16 + 4;
    localparam int          WATCHDOG_NS = (N_CYCLES + 100) * CLK_PERIOD;
    localparam logic [31:0] SEED        = 32'hb8f7_f06b;

    // What the outputs must show one cycle after an op
    typedef struct packed {
        logic                    chk;
        logic                    valid;
        logic                    chk_res1;
        logic [63:0]             res1;
        logic [63:0]             res2;
        logic [63:0]             res3;
        logic [63:0]             res4;
        logic [3:0]              wb;
        exec_pkg::op_size_e      size;
        logic                    br_valid;
        logic                    br_taken;
        logic                    br_correct;
        logic [31:0]             br_fip;
        exec_pkg::eflags_t       flags;
    } expect_t;

    logic                clk;
    logic                rst_n;
    logic                valid_in;
    exec_pkg::uop_t      uop;
    logic                valid_out;
    exec_pkg::exec_res_t res;
    exec_pkg::br_res_t   br;
    exec_pkg::eflags_t   eflags;

    exec_pkg::eflags_t   model_flags;      // Flags as seen by the next op
    expect_t             exp_next;
    expect_t             exp_cur;          // Lines up with the registered outputs

    exec_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .uop       (uop),
        .valid_out (valid_out),
        .res       (res),
        .br        (br),
        .eflags    (eflags)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        exp_cur <= exp_next;
    end

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, want);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    assert property (@(posedge clk) disable iff (!rst_n)
        exp_cur.chk |-> valid_out == exp_cur.valid)
        else report_mismatch("valid_out", 64'($sampled(valid_out)),
                             64'($sampled(exp_cur.valid)));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_cur.chk |-> res.wb == exp_cur.wb)
        else report_mismatch("wb", 64'($sampled(res.wb)), 64'($sampled(exp_cur.wb)));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_cur.chk |-> eflags == exp_cur.flags)
        else report_mismatch("eflags", 64'($sampled(eflags)), 64'($sampled(exp_cur.flags)));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_cur.chk && exp_cur.valid && exp_cur.chk_res1 |-> res.res1 == exp_cur.res1)
        else report_mismatch("res1", $sampled(res.res1), $sampled(exp_cur.res1));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_cur.chk && exp_cur.valid |-> res.res2 == exp_cur.res2)
        else report_mismatch("res2", $sampled(res.res2), $sampled(exp_cur.res2));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_cur.chk && exp_cur.valid |-> res.res3 == exp_cur.res3)
        else report_mismatch("res3", $sampled(res.res3), $sampled(exp_cur.res3));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_cur.chk && exp_cur.valid |-> res.res4 == exp_cur.res4)
        else report_mismatch("res4", $sampled(res.res4), $sampled(exp_cur.res4));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_cur.chk && exp_cur.valid |-> res.size == exp_cur.size)
        else report_mismatch("size", 64'($sampled(res.size)), 64'($sampled(exp_cur.size)));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_cur.chk |-> br.valid == exp_cur.br_valid)
        else report_mismatch("br valid", 64'($sampled(br.valid)),
                             64'($sampled(exp_cur.br_valid)));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_cur.chk && exp_cur.br_valid |-> br.taken == exp_cur.br_taken)
        else report_mismatch("br taken", 64'($sampled(br.taken)),
                             64'($sampled(exp_cur.br_taken)));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_cur.chk && exp_cur.br_valid |-> br.fip == exp_cur.br_fip)
        else report_mismatch("br fip", 64'($sampled(br.fip)), 64'($sampled(exp_cur.br_fip)));
    assert property (@(posedge clk) disable iff (!rst_n)
        exp_cur.chk && exp_cur.br_valid |-> br.correct == exp_cur.br_correct)
        else report_mismatch("br correct", 64'($sampled(br.correct)),
                             64'($sampled(exp_cur.br_correct)));

    // Reference model with x86 semantics at the op size
    task automatic model_op(input exec_pkg::uop_t u);
        int unsigned       n;
        int unsigned       cnt;
        logic [63:0]       mask;
        logic [63:0]       a;
        logic [63:0]       b;
        logic [63:0]       r;
        logic [63:0]       sx;
        logic [31:0]       step;
        logic [31:0]       tgt;
        logic              skipped;
        logic              cond_ok;
        logic              sized;
        logic              szp;
        exec_pkg::eflags_t f;
        expect_t           e;

        n       = (u.size == exec_pkg::SZ_1) ? 8 : (u.size == exec_pkg::SZ_2) ? 16 : 32;
        step    = n / 8;
        mask    = (64'd1 << n) - 64'd1;
        a       = {32'd0, u.op1.quad[31:0]} & mask;
        b       = {32'd0, u.op2.quad[31:0]} & mask;
        cnt     = 32'(u.op2.quad[4:0]);    // Count masked to five bits
        f       = model_flags;
        r       = a;
        sized   = 1'b0;
        szp     = 1'b0;
        e       = '0;
        e.chk   = 1'b1;
        e.chk_res1 = 1'b1;
        e.res1  = u.op2.quad;
        skipped = (u.op == exec_pkg::OP_CMOVC) && !model_flags.cf;

        case (u.op)
            exec_pkg::OP_ADD: begin
                r     = a + b;
                f.cf  = r[n];
                r     = r & mask;
                f.of  = (a[n-1] == b[n-1]) && (r[n-1] != a[n-1]);
                f.af  = a[4] ^ b[4] ^ r[4];
                sized = 1'b1;
                szp   = 1'b1;
            end
            exec_pkg::OP_AND, exec_pkg::OP_OR: begin
                r     = (u.op == exec_pkg::OP_AND) ? (a & b) : (a | b);
                f.cf  = 1'b0;
                f.of  = 1'b0;
                f.af  = 1'b0;
                sized = 1'b1;
                szp   = 1'b1;
            end
            exec_pkg::OP_NOT: begin
                r     = ~a & mask;   // NOT leaves every flag alone
                sized = 1'b1;
            end
            exec_pkg::OP_SAL: begin
                r     = (a << cnt) & mask;
                sized = 1'b1;
                if (cnt != 0) begin
                    f.cf = (cnt <= n) ? a[n - cnt] : 1'b0;   // Last bit out of the top
                    f.of = r[n-1] ^ f.cf;
                    f.af = 1'b0;
                    szp  = 1'b1;
                end
            end
            exec_pkg::OP_SAR: begin
                sx    = a | (a[n-1] ? ~mask : 64'd0);
                r     = (sx >> cnt) & mask;
                sized = 1'b1;
                if (cnt != 0) begin
                    f.cf = sx[cnt - 1];
                    f.of = 1'b0;
                    f.af = 1'b0;
                    szp  = 1'b1;
                end
            end
            exec_pkg::OP_PADDW: begin
                for (int i = 0; i < 4; i++) begin
                    e.res1[16*i +: 16] = u.op1.quad[16*i +: 16] + u.op2.quad[16*i +: 16];
                end
            end
            exec_pkg::OP_PADDD: begin
                for (int i = 0; i < 2; i++) begin
                    e.res1[32*i +: 32] = u.op1.quad[32*i +: 32] + u.op2.quad[32*i +: 32];
                end
            end
            exec_pkg::OP_MOV, exec_pkg::OP_CMOVC: ;
            exec_pkg::OP_JMP_NEAR, exec_pkg::OP_JCC: e.res1 = {32'd0, u.eip + u.op1.quad[31:0]};
            exec_pkg::OP_CLD: begin
                f.df       = 1'b0;
                e.chk_res1 = 1'b0;
            end
            exec_pkg::OP_STD: begin
                f.df       = 1'b1;
                e.chk_res1 = 1'b0;
            end
            default: e.chk_res1 = 1'b0;
        endcase
        if (sized) begin
            e.res1 = (u.op1.quad & ~mask) | r;   // Bytes above the op size survive
        end
        if (szp) begin
            f.zf = (r == 64'd0);
            f.sf = r[n-1];
            f.pf = ~^r[7:0];
        end

        // Pointer results use df from before this op
        e.res2 = (u.op == exec_pkg::OP_XCHG) ? u.op1.quad : u.op2.quad;
        e.res3 = u.op3.quad;
        e.res4 = u.op4.quad;
        if (u.op == exec_pkg::OP_MOVS) begin
            e.res2[31:0] = model_flags.df ? u.op2.quad[31:0] - step : u.op2.quad[31:0] + step;
            e.res3[31:0] = model_flags.df ? u.op3.quad[31:0] - step : u.op3.quad[31:0] + step;
        end
        if (u.op == exec_pkg::OP_PUSH || u.op == exec_pkg::OP_CALL_NEAR) begin
            e.res4[31:0] = u.op4.quad[31:0] - step;
        end else if (u.op == exec_pkg::OP_POP || u.op == exec_pkg::OP_RET) begin
            e.res4[31:0] = u.op4.quad[31:0] + step;
            if (u.op == exec_pkg::OP_RET && u.is_imm) begin
                e.res4[31:0] = e.res4[31:0] + u.op2.quad[31:0];
            end
        end

        if (u.cond == exec_pkg::COND_Z) cond_ok = model_flags.zf;
        else if (u.cond == exec_pkg::COND_NZ) cond_ok = !model_flags.zf;
        else if (u.cond == exec_pkg::COND_C) cond_ok = model_flags.cf;
        else cond_ok = 1'b1;
        tgt = (u.op == exec_pkg::OP_RET) ? u.op1.quad[31:0] : u.eip + u.op1.quad[31:0];
        e.br_valid   = u.op inside {exec_pkg::OP_JMP_NEAR, exec_pkg::OP_JCC,
                                    exec_pkg::OP_CALL_NEAR, exec_pkg::OP_RET};
        e.br_taken   = e.br_valid && (u.op != exec_pkg::OP_JCC || cond_ok);
        e.br_fip     = e.br_taken ? tgt : u.next_eip;
        e.br_correct = (e.br_taken == u.pred_taken) && (!e.br_taken || tgt == u.pred_target);

        if (!skipped) begin
            model_flags = (model_flags & ~u.fmask) | (f & u.fmask);
        end
        e.valid  = !skipped;
        e.wb     = skipped ? 4'd0 : u.wr_en;
        e.size   = u.size;
        e.flags  = model_flags;
        exp_next = e;
    endtask

    function automatic exec_pkg::uop_t random_uop(input exec_pkg::exec_op_e op);
        exec_pkg::uop_t u;
        logic [31:0]    rnd;

        rnd        = $urandom;
        u.op       = op;
        u.size     = (rnd[1:0] == 2'd0) ? exec_pkg::SZ_1 :
                     (rnd[1:0] == 2'd1) ? exec_pkg::SZ_2 : exec_pkg::SZ_4;
        u.op1.quad = {$urandom, $urandom};
        u.op2.quad = {$urandom, $urandom};
        u.op3.quad = {$urandom, $urandom};
        u.op4.quad = {$urandom, $urandom};
        u.fmask    = rnd[8:2];
        u.cond     = exec_pkg::cond_e'(rnd[10:9]);
        u.is_imm   = rnd[11];
        u.pred_taken  = rnd[12];
        u.wr_en       = rnd[16:13];
        u.eip         = $urandom;
        u.next_eip    = $urandom;
        u.pred_target = $urandom;
        if (rnd[17]) begin
            u.pred_target = (op == exec_pkg::OP_RET) ? u.op1.quad[31:0]
                                                     : u.eip + u.op1.quad[31:0];
        end
        if (op == exec_pkg::OP_CLD || op == exec_pkg::OP_STD) begin
            u.fmask.df = 1'b1;
        end
        return u;
    endfunction

    task automatic drive_op(input exec_pkg::uop_t u);
        @(posedge clk);
        #1;
        uop      = u;
        valid_in = 1'b1;
        model_op(u);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        valid_in       = 1'b0;
        exp_next       = '0;
        exp_next.chk   = 1'b1;
        exp_next.flags = model_flags;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1);
    end

    initial begin
        exec_pkg::uop_t u;
        logic [31:0]    idx;

        void'($urandom(SEED));
        rst_n       = 1'b0;
        valid_in    = 1'b0;
        uop         = '0;
        model_flags = '0;
        exp_next    = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (!valid_out && !br.valid && res.wb == 4'd0 && eflags == 7'd0)
            else report_mismatch("reset state", 64'({valid_out, br.valid, res.wb, eflags}),
                                 64'd0);

        drive_op(random_uop(exec_pkg::OP_CLD));
        drive_op(random_uop(exec_pkg::OP_MOVS));
        drive_op(random_uop(exec_pkg::OP_STD));
        drive_op(random_uop(exec_pkg::OP_MOVS));
        u = random_uop(exec_pkg::OP_ADD);   // 0xff + 1 sets carry
        u.size = exec_pkg::SZ_1;
        u.op1.quad[7:0] = 8'hff;
        u.op2.quad[7:0] = 8'h01;
        u.fmask.cf = 1'b1;
        drive_op(u);
        drive_op(random_uop(exec_pkg::OP_CMOVC));
        u = random_uop(exec_pkg::OP_AND);
        u.fmask.cf = 1'b1;
        drive_op(u);
        drive_op(random_uop(exec_pkg::OP_CMOVC));   // Skipped
        drive_op(random_uop(exec_pkg::OP_XCHG));
        drive_op(random_uop(exec_pkg::OP_PUSH));
        drive_op(random_uop(exec_pkg::OP_POP));
        drive_op(random_uop(exec_pkg::OP_CALL_NEAR));
        u = random_uop(exec_pkg::OP_RET);
        u.is_imm = 1'b1;
        drive_op(u);
        u.is_imm = 1'b0;
        drive_op(u);
        drive_idle();

        for (int i = 0; i < N_RANDOM; i++) begin
            idx = $urandom_range(19);
            drive_op(random_uop(exec_pkg::exec_op_e'(idx[4:0])));
            if (i % 16 == 15) begin
                drive_idle();
            end
        end
        drive_idle();
        drive_idle();
        $display("*** PASSED ***");
        $finish;
    end

endmodule
